/* hw/ex_alu.sv */
`timescale 1ns/1ns
`include "rv_ex_config.svh"

module ex_alu (
    input  logic [`EX_XLEN-1:0]  a_i,
    input  logic [`EX_XLEN-1:0]  b_i,
    input  rv_ex_pkg::alu_op_e   op_i,
    output logic [`EX_XLEN-1:0]  r_o
);

    logic lt_s;
    logic lt_u;

    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (op_i)
            rv_ex_pkg::ALU_ADD:  r_o = a_i + b_i;
            rv_ex_pkg::ALU_SUB:  r_o = a_i - b_i;
            rv_ex_pkg::ALU_SLT:  r_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
            rv_ex_pkg::ALU_SLTU: r_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
            rv_ex_pkg::ALU_XOR:  r_o = a_i ^ b_i;
            rv_ex_pkg::ALU_OR:   r_o = a_i | b_i;
            rv_ex_pkg::ALU_AND:  r_o = a_i & b_i;
            // Shifts run in the serial shifter
            rv_ex_pkg::ALU_SLL,
            rv_ex_pkg::ALU_SRL,
            rv_ex_pkg::ALU_SRA:  r_o = a_i;
            default:             r_o = '0;
        endcase
    end

endmodule

/* hw/ex_control.sv */
`timescale 1ns/1ns
`include "rv_ex_config.svh"

module ex_control (
    input  logic                 clk,
    input  logic                 resetn_i,
    input  logic                 id_give_i,
    input  logic                 mem_get_i,
    input  logic [`EX_ILEN-1:0]  instr_i,
    output logic                 ex_get_o,
    output logic                 ex_give_o,
    ex_ctrl_if.ctrl              ctrl_if
);

    rv_ex_pkg::ex_state_e state_q;
    rv_ex_pkg::ex_state_e state_d;

    logic [6:0] opc;
    logic [2:0] f3;
    logic       b30;
    logic       is_shift;

    assign opc = instr_i[`EX_OPC_MSB:`EX_OPC_LSB];
    assign f3  = instr_i[`EX_F3_MSB:`EX_F3_LSB];
    assign b30 = instr_i[`EX_F7_BIT];

    // Decode of the latched instruction, stable from ST_EXEC to ST_GIVE
    always_comb begin
        ctrl_if.alu_op  = rv_ex_pkg::ALU_ADD;
        ctrl_if.sel_pc  = 1'b0;
        ctrl_if.sel_imm = 1'b0;
        case (opc)
            rv_ex_pkg::OPC_LUI,
            rv_ex_pkg::OPC_LOAD,
            rv_ex_pkg::OPC_STORE: begin
                ctrl_if.sel_imm = 1'b1; // Address or upper immediate
            end
            rv_ex_pkg::OPC_OP_IMM: begin
                ctrl_if.sel_imm = 1'b1;
                // Bit 30 is part of the immediate except for SRAI
                if (f3 == 3'b101)
                    ctrl_if.alu_op = rv_ex_pkg::alu_op_e'({b30, f3});
                else
                    ctrl_if.alu_op = rv_ex_pkg::alu_op_e'({1'b0, f3});
            end
            rv_ex_pkg::OPC_OP: begin
                ctrl_if.alu_op = rv_ex_pkg::alu_op_e'({b30, f3});
            end
            rv_ex_pkg::OPC_BRANCH: begin
                ctrl_if.sel_pc  = 1'b1; // Target is pc + imm
                ctrl_if.sel_imm = 1'b1;
            end
            default: begin
                // Not an ALU op, so the result comes out zero
                ctrl_if.alu_op = rv_ex_pkg::alu_op_e'(4'b1111);
            end
        endcase
    end

    assign is_shift = (ctrl_if.alu_op == rv_ex_pkg::ALU_SLL) ||
                      (ctrl_if.alu_op == rv_ex_pkg::ALU_SRL) ||
                      (ctrl_if.alu_op == rv_ex_pkg::ALU_SRA);

    assign ex_get_o  = (state_q == rv_ex_pkg::ST_GET);
    assign ex_give_o = (state_q == rv_ex_pkg::ST_GIVE);

    always_comb begin
        state_d            = state_q;
        ctrl_if.op_latch   = 1'b0;
        ctrl_if.res_load   = 1'b0;
        ctrl_if.shift_load = 1'b0;
        ctrl_if.shift_step = 1'b0;
        case (state_q)
            rv_ex_pkg::ST_GET: begin
                if (id_give_i) begin
                    ctrl_if.op_latch = 1'b1;
                    state_d          = rv_ex_pkg::ST_EXEC;
                end
            end
            rv_ex_pkg::ST_EXEC: begin
                if (is_shift) begin
                    ctrl_if.shift_load = 1'b1;
                    // Zero amount skips ST_SHIFT
                    state_d = ctrl_if.shift_done ? rv_ex_pkg::ST_GIVE : rv_ex_pkg::ST_SHIFT;
                end else begin
                    ctrl_if.res_load = 1'b1;
                    state_d          = rv_ex_pkg::ST_GIVE;
                end
            end
            rv_ex_pkg::ST_SHIFT: begin
                ctrl_if.shift_step = 1'b1; // One bit per cycle
                if (ctrl_if.shift_done)
                    state_d = rv_ex_pkg::ST_GIVE;
            end
            rv_ex_pkg::ST_GIVE: begin
                if (mem_get_i)
                    state_d = rv_ex_pkg::ST_GET;
            end
            default: begin
                state_d = rv_ex_pkg::ST_GET;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn_i)
            state_q <= rv_ex_pkg::ST_GET;
        else
            state_q <= state_d;
    end

endmodule

/* hw/ex_ctrl_if.sv */
`timescale 1ns/1ns

interface ex_ctrl_if;

    logic                 op_latch;   // Capture incoming operands
    rv_ex_pkg::alu_op_e   alu_op;
    logic                 sel_pc;     // ALU A is pc
    logic                 sel_imm;    // ALU B is imm
    logic                 res_load;
    logic                 shift_load;
    logic                 shift_step;
    logic                 shift_done; // From the counter

    modport ctrl (
        output op_latch, alu_op, sel_pc, sel_imm,
        output res_load, shift_load, shift_step,
        input  shift_done
    );

    modport dp (
        input op_latch, alu_op, sel_pc, sel_imm,
        input res_load, shift_load, shift_step
    );

    // Counter only sees the shift strobes
    modport cnt (
        input  shift_load, shift_step,
        output shift_done
    );

endinterface

/* hw/ex_datapath.sv */
`timescale 1ns/1ns
`include "rv_ex_config.svh"

module ex_datapath (
    input  logic                    clk,
    input  logic                    resetn_i,
    input  logic [`EX_ILEN-1:0]     id_instr_i,
    input  logic [`EX_XLEN-1:0]     id_pc_i,
    input  logic [`EX_XLEN-1:0]     id_rs1_i,
    input  logic [`EX_XLEN-1:0]     id_rs2_i,
    input  logic [`EX_XLEN-1:0]     id_imm_i,
    ex_ctrl_if.dp                   ctrl_if,
    output logic [`EX_ILEN-1:0]     instr_o,
    output logic [`EX_XLEN-1:0]     result_o,
    output logic [`EX_XLEN-1:0]     rs2_o,
    output logic                    branch_taken_o,
    output logic [`EX_SHAMT_W-1:0]  shamt_o
);

    logic [`EX_ILEN-1:0] instr_q;
    logic [`EX_XLEN-1:0] pc_q;
    logic [`EX_XLEN-1:0] rs1_q;
    logic [`EX_XLEN-1:0] rs2_q;
    logic [`EX_XLEN-1:0] imm_q;

    logic [`EX_XLEN-1:0] alu_a;
    logic [`EX_XLEN-1:0] alu_b;
    logic [`EX_XLEN-1:0] alu_r;

    logic [`EX_XLEN-1:0] res_q;  // Also the serial shift register
    logic                taken_q;
    logic                is_branch;
    logic                cmp;

    always_ff @(posedge clk) begin
        if (ctrl_if.op_latch) begin
            instr_q <= id_instr_i;
            pc_q    <= id_pc_i;
            // LUI adds the immediate to zero
            if (id_instr_i[`EX_OPC_MSB:`EX_OPC_LSB] == rv_ex_pkg::OPC_LUI)
                rs1_q <= '0;
            else
                rs1_q <= id_rs1_i;
            rs2_q   <= id_rs2_i;
            imm_q   <= id_imm_i;
        end
    end

    assign alu_a = ctrl_if.sel_pc  ? pc_q  : rs1_q;
    assign alu_b = ctrl_if.sel_imm ? imm_q : rs2_q;

    ex_alu i_ex_alu (
        .a_i  (alu_a),
        .b_i  (alu_b),
        .op_i (ctrl_if.alu_op),
        .r_o  (alu_r)
    );

    // Shift amount from imm for OP_IMM, from rs2 for OP
    assign shamt_o = ctrl_if.sel_imm ? imm_q[`EX_SHAMT_W-1:0] : rs2_q[`EX_SHAMT_W-1:0];

    assign is_branch = (instr_q[`EX_OPC_MSB:`EX_OPC_LSB] == rv_ex_pkg::OPC_BRANCH);

    always_comb begin
        case (instr_q[`EX_F3_MSB:`EX_F3_LSB])
            3'b000:  cmp = (rs1_q == rs2_q);                  // BEQ
            3'b001:  cmp = (rs1_q != rs2_q);                  // BNE
            3'b100:  cmp = ($signed(rs1_q) <  $signed(rs2_q)); // BLT
            3'b101:  cmp = ($signed(rs1_q) >= $signed(rs2_q)); // BGE
            3'b110:  cmp = (rs1_q <  rs2_q);                  // BLTU
            3'b111:  cmp = (rs1_q >= rs2_q);                  // BGEU
            default: cmp = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            res_q   <= '0;
            taken_q <= 1'b0;
        end else if (ctrl_if.res_load) begin
            res_q   <= alu_r;
            taken_q <= is_branch && cmp;
        end else if (ctrl_if.shift_load) begin
            res_q   <= rs1_q;
            taken_q <= 1'b0;
        end else if (ctrl_if.shift_step) begin
            case (ctrl_if.alu_op)
                rv_ex_pkg::ALU_SLL: res_q <= {res_q[`EX_XLEN-2:0], 1'b0};
                rv_ex_pkg::ALU_SRL: res_q <= {1'b0, res_q[`EX_XLEN-1:1]};
                rv_ex_pkg::ALU_SRA: res_q <= {res_q[`EX_XLEN-1], res_q[`EX_XLEN-1:1]};
                default:            res_q <= res_q;
            endcase
        end
    end

    assign instr_o        = instr_q;
    assign result_o       = res_q;
    assign rs2_o          = rs2_q; // Store data
    assign branch_taken_o = taken_q;

endmodule

/* hw/ex_shift_counter.sv */
`timescale 1ns/1ns
`include "rv_ex_config.svh"

module ex_shift_counter (
    input  logic                    clk,
    input  logic                    resetn_i,
    input  logic [`EX_SHAMT_W-1:0]  shamt_i,
    ex_ctrl_if.cnt                  ctrl_if
);

    logic [`EX_SHAMT_W-1:0] count_q;
    logic [`EX_SHAMT_W-1:0] count_d;

    always_comb begin
        count_d = count_q;
        if (ctrl_if.shift_load)
            count_d = shamt_i;
        else if (ctrl_if.shift_step && (count_q != '0))
            count_d = count_q - 1'b1;
    end

    // Looks at the next count so the last step ends ST_SHIFT on time,
    // and a zero amount is seen already at the load
    assign ctrl_if.shift_done = (count_d == '0);

    always_ff @(posedge clk) begin
        if (!resetn_i)
            count_q <= '0;
        else
            count_q <= count_d;
    end

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/1ns
`include "rv_ex_config.svh"

module ex_stage (
    input  logic                 clk,
    input  logic                 resetn_i,
    // Decode side
    input  logic                 id_give_i,
    input  logic [`EX_ILEN-1:0]  id_instr_i,
    input  logic [`EX_XLEN-1:0]  id_pc_i,
    input  logic [`EX_XLEN-1:0]  id_rs1_i,
    input  logic [`EX_XLEN-1:0]  id_rs2_i,
    input  logic [`EX_XLEN-1:0]  id_imm_i,
    output logic                 ex_get_o,
    // Memory side
    input  logic                 mem_get_i,
    output logic                 ex_give_o,
    output logic [`EX_ILEN-1:0]  ex_instr_o,
    output logic [`EX_XLEN-1:0]  ex_result_o,
    output logic [`EX_XLEN-1:0]  ex_rs2_o,
    output logic                 branch_taken_o
);

    logic [`EX_SHAMT_W-1:0] shamt;

    ex_ctrl_if ctrl_if ();

    ex_control i_ex_control (
        .clk       (clk),
        .resetn_i  (resetn_i),
        .id_give_i (id_give_i),
        .mem_get_i (mem_get_i),
        .instr_i   (ex_instr_o), // Latched copy
        .ex_get_o  (ex_get_o),
        .ex_give_o (ex_give_o),
        .ctrl_if   (ctrl_if.ctrl)
    );

    ex_shift_counter i_ex_shift_counter (
        .clk      (clk),
        .resetn_i (resetn_i),
        .shamt_i  (shamt),
        .ctrl_if  (ctrl_if.cnt)
    );

    ex_datapath i_ex_datapath (
        .clk            (clk),
        .resetn_i       (resetn_i),
        .id_instr_i     (id_instr_i),
        .id_pc_i        (id_pc_i),
        .id_rs1_i       (id_rs1_i),
        .id_rs2_i       (id_rs2_i),
        .id_imm_i       (id_imm_i),
        .ctrl_if        (ctrl_if.dp),
        .instr_o        (ex_instr_o),
        .result_o       (ex_result_o),
        .rs2_o          (ex_rs2_o),
        .branch_taken_o (branch_taken_o),
        .shamt_o        (shamt)
    );

endmodule

/* hw/rv_ex_config.svh */
`ifndef RV_EX_CONFIG_SVH
`define RV_EX_CONFIG_SVH

`define EX_XLEN    32 // Data path width
`define EX_ILEN    32
`define EX_SHAMT_W 5

// Instruction fields
`define EX_OPC_MSB 6
`define EX_OPC_LSB 0
`define EX_F3_MSB  14
`define EX_F3_LSB  12
`define EX_F7_BIT  30 // Picks SUB and SRA

`endif

/* hw/rv_ex_pkg.sv */
package rv_ex_pkg;

    // Major opcodes handled by the stage
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // {instr[30], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_GET   = 2'd0,
        ST_EXEC  = 2'd1,
        ST_SHIFT = 2'd2,
        ST_GIVE  = 2'd3
    } ex_state_e;

endpackage

/* test/ex_stage_sva.sv */
`timescale 1ns/1ns
`include "rv_ex_config.svh"

module ex_stage_sva (
    input logic                clk,
    input logic                resetn_i,
    input logic                ex_get_o,
    input logic                ex_give_o,
    input logic                mem_get_i,
    input logic [`EX_XLEN-1:0] ex_result_o
);

    int err_cnt = 0;

    // Decode side and memory side never offer at once
    get_give_excl: assert property (@(posedge clk) disable iff (!resetn_i)
        !(ex_get_o && ex_give_o))
        else begin
            $error("ex_get_o and ex_give_o are high in the same cycle");
            err_cnt++;
        end

    hold_on_stall: assert property (@(posedge clk) disable iff (!resetn_i)
        (ex_give_o && !mem_get_i) |=> (ex_give_o && $stable(ex_result_o)))
        else begin
            $error("Result or ex_give_o changed while mem_get_i was low");
            err_cnt++;
        end

    give_low_after_reset: assert property (@(posedge clk)
        !resetn_i |=> !ex_give_o)
        else begin
            $error("ex_give_o is high in the cycle after reset");
            err_cnt++;
        end

endmodule

bind ex_stage ex_stage_sva i_ex_stage_sva (
    .clk         (clk),
    .resetn_i    (resetn_i),
    .ex_get_o    (ex_get_o),
    .ex_give_o   (ex_give_o),
    .mem_get_i   (mem_get_i),
    .ex_result_o (ex_result_o)
);

/* test/ex_stage_tb.sv */
`timescale 1ns/1ns
`include "rv_ex_config.svh"

module ex_stage_tb;

    typedef struct {
        logic [6:0] opc;
        logic [2:0] f3;
        logic       b30;
        logic       use_imm;
        logic [1:0] mode;     // 1 gives rs1 < 0 <= rs2, 2 gives rs1 == rs2
        int         shamt;    // -1 keeps the random amount
        int         wait_cyc; // Cycles of back-pressure
    } entry_t;

    localparam int NUM = 28;
    localparam int TMO = 100;

    entry_t tests [NUM] = '{
        '{rv_ex_pkg::OPC_OP,     3'b000, 1'b0, 1'b0, 2'd0, -1, 0}, // ADD
        '{rv_ex_pkg::OPC_OP,     3'b000, 1'b1, 1'b0, 2'd0, -1, 0}, // SUB
        '{rv_ex_pkg::OPC_OP,     3'b010, 1'b0, 1'b0, 2'd1, -1, 0},
        '{rv_ex_pkg::OPC_OP,     3'b011, 1'b0, 1'b0, 2'd1, -1, 1},
        '{rv_ex_pkg::OPC_OP,     3'b100, 1'b0, 1'b0, 2'd0, -1, 0},
        '{rv_ex_pkg::OPC_OP,     3'b110, 1'b0, 1'b0, 2'd0, -1, 0},
        '{rv_ex_pkg::OPC_OP,     3'b111, 1'b0, 1'b0, 2'd0, -1, 0},
        '{rv_ex_pkg::OPC_OP_IMM, 3'b000, 1'b1, 1'b1, 2'd0, -1, 0}, // ADDI with bit 30 in imm
        '{rv_ex_pkg::OPC_OP_IMM, 3'b010, 1'b0, 1'b1, 2'd1, -1, 0},
        '{rv_ex_pkg::OPC_OP_IMM, 3'b011, 1'b0, 1'b1, 2'd1, -1, 0},
        '{rv_ex_pkg::OPC_OP_IMM, 3'b111, 1'b0, 1'b1, 2'd0, -1, 2},
        '{rv_ex_pkg::OPC_LUI,    3'b000, 1'b0, 1'b1, 2'd0, -1, 0},
        '{rv_ex_pkg::OPC_LOAD,   3'b010, 1'b0, 1'b1, 2'd0, -1, 3},
        '{rv_ex_pkg::OPC_STORE,  3'b010, 1'b0, 1'b1, 2'd0, -1, 1},
        '{rv_ex_pkg::OPC_BRANCH, 3'b000, 1'b0, 1'b0, 2'd2, -1, 0}, // BEQ taken
        '{rv_ex_pkg::OPC_BRANCH, 3'b001, 1'b0, 1'b0, 2'd0, -1, 0},
        '{rv_ex_pkg::OPC_BRANCH, 3'b100, 1'b0, 1'b0, 2'd1, -1, 0},
        '{rv_ex_pkg::OPC_BRANCH, 3'b101, 1'b0, 1'b0, 2'd1, -1, 2},
        '{rv_ex_pkg::OPC_BRANCH, 3'b101, 1'b0, 1'b0, 2'd2, -1, 0},
        '{rv_ex_pkg::OPC_BRANCH, 3'b110, 1'b0, 1'b0, 2'd1, -1, 0},
        '{rv_ex_pkg::OPC_BRANCH, 3'b111, 1'b0, 1'b0, 2'd1, -1, 0},
        '{rv_ex_pkg::OPC_OP_IMM, 3'b001, 1'b0, 1'b1, 2'd0, 0, 0},  // SLLI by 0
        '{rv_ex_pkg::OPC_OP_IMM, 3'b101, 1'b0, 1'b1, 2'd0, 1, 0},
        '{rv_ex_pkg::OPC_OP_IMM, 3'b101, 1'b1, 1'b1, 2'd1, 31, 2}, // SRAI by 31
        '{rv_ex_pkg::OPC_OP,     3'b001, 1'b0, 1'b0, 2'd0, -1, 0},
        '{rv_ex_pkg::OPC_OP,     3'b101, 1'b0, 1'b0, 2'd0, -1, 1},
        '{rv_ex_pkg::OPC_OP,     3'b101, 1'b1, 1'b0, 2'd1, -1, 0},
        '{7'b1110011,            3'b000, 1'b0, 1'b0, 2'd0, -1, 0}  // SYSTEM is not handled
    };

    logic                clk = 1'b0;
    logic                resetn_i;
    logic                id_give_i;
    logic [`EX_ILEN-1:0] id_instr_i;
    logic [`EX_XLEN-1:0] id_pc_i;
    logic [`EX_XLEN-1:0] id_rs1_i;
    logic [`EX_XLEN-1:0] id_rs2_i;
    logic [`EX_XLEN-1:0] id_imm_i;
    logic                mem_get_i;
    logic                ex_get_o;
    logic                ex_give_o;
    logic [`EX_ILEN-1:0] ex_instr_o;
    logic [`EX_XLEN-1:0] ex_result_o;
    logic [`EX_XLEN-1:0] ex_rs2_o;
    logic                branch_taken_o;

    logic [31:0] lfsr = 32'd67901;
    int          errs;

    ex_stage i_ex_stage (.*);

    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [`EX_XLEN-1:0] rand_word();
        logic [`EX_XLEN-1:0] v;
        logic                fb;
        v = '0;
        for (int i = 0; i < `EX_XLEN; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[`EX_XLEN-2:0], fb};
        end
        return v;
    endfunction

    function automatic void ref_model(input entry_t e, input logic [`EX_XLEN-1:0] rs1, rs2,
                                      input logic [`EX_XLEN-1:0] pc, imm,
                                      output logic [`EX_XLEN-1:0] res, output logic taken,
                                      output int lat);
        logic [`EX_XLEN-1:0] b;
        logic [4:0]          sh;
        b     = e.use_imm ? imm : rs2;
        sh    = b[4:0];
        res   = '0;
        taken = 1'b0;
        lat   = 2;
        case (e.opc)
            rv_ex_pkg::OPC_LUI:    res = imm;
            rv_ex_pkg::OPC_LOAD,
            rv_ex_pkg::OPC_STORE:  res = rs1 + imm;
            rv_ex_pkg::OPC_BRANCH: begin
                res = pc + imm;
                case (e.f3)
                    3'b000:  taken = (rs1 == rs2);
                    3'b001:  taken = (rs1 != rs2);
                    3'b100:  taken = ($signed(rs1) < $signed(rs2));
                    3'b101:  taken = ($signed(rs1) >= $signed(rs2));
                    3'b110:  taken = (rs1 < rs2);
                    3'b111:  taken = (rs1 >= rs2);
                    default: taken = 1'b0;
                endcase
            end
            rv_ex_pkg::OPC_OP,
            rv_ex_pkg::OPC_OP_IMM: begin
                case (e.f3)
                    3'b000:  res = (e.b30 && !e.use_imm) ? rs1 - b : rs1 + b;
                    3'b001:  res = rs1 << sh;
                    3'b010:  res = ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011:  res = (rs1 < b) ? 32'd1 : 32'd0;
                    3'b100:  res = rs1 ^ b;
                    3'b101: begin
                        if (e.b30)
                            res = $signed(rs1) >>> sh;
                        else
                            res = rs1 >> sh;
                    end
                    3'b110:  res = rs1 | b;
                    default: res = rs1 & b;
                endcase
                if (e.f3 == 3'b001 || e.f3 == 3'b101)
                    lat = 2 + sh; // One cycle per shifted bit
            end
            default: res = '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    initial begin
        logic [`EX_XLEN-1:0] instr, rs1, rs2, pc, imm, exp_res;
        logic                exp_taken;
        int                  n, lat, exp_lat, fails;
        resetn_i   = 1'b0;
        id_give_i  = 1'b0;
        id_instr_i = '0;
        id_pc_i    = '0;
        id_rs1_i   = '0;
        id_rs2_i   = '0;
        id_imm_i   = '0;
        mem_get_i  = 1'b0;
        fails      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn_i = 1'b1;
        @(negedge clk);
        errs = 0;
        check_value("ex_give_o", ex_give_o, 0);
        check_value("branch_taken_o", branch_taken_o, 0);
        check_value("ex_get_o", ex_get_o, 1);
        $display("Test 0 reset: %s", (errs == 0) ? "pass" : "FAIL");
        if (errs != 0)
            fails++;

        for (int t = 0; t < NUM; t++) begin
            errs  = 0;
            instr = rand_word();
            rs1   = rand_word();
            rs2   = rand_word();
            pc    = rand_word();
            imm   = rand_word();
            instr[6:0]   = tests[t].opc;
            instr[14:12] = tests[t].f3;
            instr[30]    = tests[t].b30;
            if (tests[t].mode == 2'd1) begin
                rs1[31] = 1'b1; // Signed and unsigned order disagree
                rs2[31] = 1'b0;
                imm[31] = 1'b0;
            end else if (tests[t].mode == 2'd2) begin
                rs2 = rs1;
            end
            if (tests[t].shamt >= 0) begin
                if (tests[t].use_imm)
                    imm[4:0] = tests[t].shamt[4:0];
                else
                    rs2[4:0] = tests[t].shamt[4:0];
            end
            ref_model(tests[t], rs1, rs2, pc, imm, exp_res, exp_taken, exp_lat);

            id_instr_i = instr;
            id_pc_i    = pc;
            id_rs1_i   = rs1;
            id_rs2_i   = rs2;
            id_imm_i   = imm;
            id_give_i  = 1'b1;
            n = 0;
            while (!ex_get_o && n < TMO) begin
                @(negedge clk);
                n++;
            end
            if (!ex_get_o) begin
                $display("Timeout: the stage never became ready in test %0d", t + 1);
                $display("Something failed");
                $finish;
            end
            @(negedge clk); // Accept edge is behind us
            id_give_i = 1'b0;
            lat = 1;
            while (!ex_give_o && lat < TMO) begin
                check_value("ex_get_o", ex_get_o, 0);
                @(negedge clk);
                lat++;
            end
            if (!ex_give_o) begin
                $display("Timeout: no result was offered in test %0d", t + 1);
                $display("Something failed");
                $finish;
            end
            check_value("ex_give_o delay", lat, exp_lat);
            check_value("ex_result_o", ex_result_o, exp_res);
            check_value("branch_taken_o", branch_taken_o, exp_taken);
            check_value("ex_rs2_o", ex_rs2_o, rs2);
            check_value("ex_instr_o", ex_instr_o, instr);
            repeat (tests[t].wait_cyc) begin
                @(negedge clk);
                check_value("ex_give_o", ex_give_o, 1);
                check_value("ex_get_o", ex_get_o, 0);
                check_value("ex_result_o", ex_result_o, exp_res);
                check_value("branch_taken_o", branch_taken_o, exp_taken);
                check_value("ex_rs2_o", ex_rs2_o, rs2);
                check_value("ex_instr_o", ex_instr_o, instr);
            end
            mem_get_i = 1'b1;
            @(negedge clk);
            mem_get_i = 1'b0;
            check_value("ex_give_o", ex_give_o, 0);
            check_value("ex_get_o", ex_get_o, 1);
            $display("Test %0d opcode %b funct3 %b bit30 %b: %s", t + 1, tests[t].opc,
                     tests[t].f3, tests[t].b30, (errs == 0) ? "pass" : "FAIL");
            if (errs != 0)
                fails++;
        end

        $display("%0d tests, %0d passed, %0d failed, %0d assertion errors", NUM + 1,
                 NUM + 1 - fails, fails, i_ex_stage.i_ex_stage_sva.err_cnt);
        if (fails == 0 && i_ex_stage.i_ex_stage_sva.err_cnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
hw/rv_ex_pkg.sv
hw/ex_ctrl_if.sv
hw/ex_alu.sv
hw/ex_shift_counter.sv
hw/ex_control.sv
hw/ex_datapath.sv
hw/ex_stage.sv
test/ex_stage_sva.sv
test/ex_stage_tb.sv
